//--- acq/acq_hit_packer.sv
`timescale 1ns/1ps

// Hit words from trigger falling edges during acquisition
module acq_hit_packer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_stop,
    input  logic [2:0]             trigger_b,
    output sc_test_pkg::usb_word_t wr_din,
    output logic                   wr_en,
    input  logic                   fifo_full
);

    logic                 start_d;
    logic [2:0]           trig_s1;
    logic [2:0]           trig_s2;
    logic [2:0]           trig_fall;
    sc_test_pkg::tstamp_t tstamp;

    ////////////////////////////////////////
    // Pin sync and timestamp
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            start_d <= 1'b0;
            trig_s1 <= 3'b111;
            trig_s2 <= 3'b111;
            tstamp  <= '0;
        end else begin
            start_d <= start_stop;
            trig_s1 <= trigger_b;
            trig_s2 <= trig_s1;
            // Restart at each run, free running while high
            if (start_stop && !start_d) tstamp <= '0;
            else if (start_stop) tstamp <= tstamp + 1'b1;
        end
    end

    assign trig_fall = trig_s2 & ~trig_s1;

    ////////////////////////////////////////
    // Hit word, one cycle after the edge
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) wr_en <= 1'b0;
        // Dropped while full
        else wr_en <= start_stop && (|trig_fall) && !fifo_full;
        // Low pins shown as ones
        wr_din <= {sc_test_pkg::TAG_HIT, ~trig_s1, tstamp};
    end

endmodule

//--- all.f
+incdir+common
common/sc_test_pkg.sv
common/sc_param_if.sv
verilog/acq_or_sctest_switch.sv
sctest/sctest_ctrl.sv
acq/acq_hit_packer.sv
verilog/usb_data_fifo.sv
verilog/scurve_top.sv
bench/clk_gen.sv
bench/tb_scurve_top.sv

//--- bench/clk_gen.sv
`timescale 1ns/1ps

// Free running testbench clock and power-on reset
module clk_gen #(
    parameter int PERIOD_NS  = 4,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset high from time zero, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- bench/tb_scurve_top.sv
`timescale 1ns/1ps
`include "sc_test_cfg.svh"

// Readout core testbench, acquisition mode first, then two S-curve scans
module tb_scurve_top;

    // One scan step, load plus settle plus window plus the two writes
    localparam int STEP_CYCLES = `SC_SETTLE_CYCLES + `SC_WINDOW_CYCLES + 4;
    localparam int SCAN_CODES  = 5;
    // Long enough to overrun the FIFO, two words per code
    localparam int LONG_CODES  = 40;
    localparam int HITS        = 8;
    localparam int WATCHDOG_NS = ((SCAN_CODES + LONG_CODES) * STEP_CYCLES + 5000) * 4;

    logic                     clk;
    logic                     rst;
    logic                     acq_or_sctest;
    logic                     usb_start_stop;
    sc_test_pkg::ctest_mask_t usb_ctest_chn;
    sc_test_pkg::dac_code_t   usb_dac0;
    sc_test_pkg::dac_code_t   usb_dac1;
    sc_test_pkg::dac_code_t   usb_dac2;
    logic                     usb_param_load;
    sc_test_pkg::chn_idx_t    sc_chn;
    sc_test_pkg::dac_code_t   dac_start;
    sc_test_pkg::dac_code_t   dac_stop;
    logic [2:0]               trigger_b;
    sc_test_pkg::ctest_mask_t chip_ctest_chn;
    sc_test_pkg::dac_code_t   chip_dac0;
    sc_test_pkg::dac_code_t   chip_dac1;
    sc_test_pkg::dac_code_t   chip_dac2;
    logic                     chip_param_load;
    logic                     rd_en;
    sc_test_pkg::usb_word_t   rd_data;
    logic                     empty;

    // Pin drive from the hit test and from the scan trigger model
    logic [2:0]               hit_drive;
    logic                     scan_trig = 1'b1;
    int                       errors    = 0;
    int                       test_errs = 0;
    // Chip parameter loads seen in test mode, and the count at scan start
    int                       load_cnt  = 0;
    int                       load_base = 0;
    logic [2:0]               hit_pins[$];

    clk_gen u_clk (.clk, .rst);

    scurve_top DUT (.*);

    // Trigger pins idle high, pin 0 shared by both drivers
    assign trigger_b = {hit_drive[2:1], hit_drive[0] & scan_trig};

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////
    task automatic note_failure(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished, %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    ////////////////////////////////////////
    // Host side FIFO reader
    ////////////////////////////////////////
    // Show-ahead head word taken on the falling edge, popped one edge later
    task automatic read_word(output sc_test_pkg::usb_word_t w);
        @(negedge clk);
        while (empty) @(negedge clk);
        w = rd_data;
        @(posedge clk);
        rd_en <= 1'b1;
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    // Code word then count word per code, one end word last
    task automatic check_scan(input sc_test_pkg::dac_code_t first, input int codes);
        sc_test_pkg::usb_word_t w;
        sc_test_pkg::dac_code_t c;
        for (int i = 0; i < codes; i++) begin
            c = first + 10'(i);
            read_word(w);
            assert (w == {sc_test_pkg::TAG_CODE, 4'b0000, c})
                else note_failure($sformatf("code word %h, expected code %0d", w, c));
            read_word(w);
            // Pulse count set by the trigger model
            assert (w == {sc_test_pkg::TAG_COUNT, 14'(c % 8)})
                else note_failure($sformatf("count word %h for code %0d", w, c));
        end
        read_word(w);
        assert (w == {sc_test_pkg::TAG_END, 14'd0})
            else note_failure($sformatf("end word %h", w));
    endtask

    ////////////////////////////////////////
    // Trigger model for the scan
    ////////////////////////////////////////
    // Pulses start two cycles into the count window, 10 cycles apart
    task automatic pulse_trigger0(input int n);
        repeat (`SC_SETTLE_CYCLES + 2) @(posedge clk);
        for (int i = 0; i < n; i++) begin
            scan_trig <= 1'b0;
            repeat (3) @(posedge clk);
            scan_trig <= 1'b1;
            repeat (7) @(posedge clk);
        end
    endtask

    // Each load in test mode checks the chip ports, then drives triggers
    always begin
        sc_test_pkg::dac_code_t exp_code;
        @(negedge clk);
        if (!rst && !acq_or_sctest && chip_param_load) begin
            exp_code = dac_start + 10'(load_cnt - load_base);
            assert (chip_dac0 == exp_code && chip_dac1 == exp_code && chip_dac2 == exp_code)
                else note_failure($sformatf("DAC %0d, expected %0d", chip_dac0, exp_code));
            assert ($countones(chip_ctest_chn) == 1 && chip_ctest_chn[sc_chn])
                else note_failure($sformatf("test mask %h, channel %0d", chip_ctest_chn,
                                            sc_chn));
            load_cnt++;
            pulse_trigger0(exp_code % 8);
        end
    end

    ////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////
    // Host parameters reach the chip in the same cycle
    assert property (@(posedge clk) disable iff (rst)
        acq_or_sctest |-> (chip_ctest_chn == usb_ctest_chn && chip_dac0 == usb_dac0 &&
                           chip_dac1 == usb_dac1 && chip_dac2 == usb_dac2 &&
                           chip_param_load == usb_param_load))
        else note_failure("chip parameters differ from host inputs");

    // Only hit words leave the FIFO in acquisition
    assert property (@(posedge clk) disable iff (rst)
        (acq_or_sctest && rd_en && !empty) |-> rd_data[15:14] == sc_test_pkg::TAG_HIT)
        else note_failure("scan word read in acquisition mode");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        sc_test_pkg::usb_word_t w;
        sc_test_pkg::dac_code_t first;
        logic [2:0]             pins;
        sc_test_pkg::tstamp_t   last_ts;
        void'($urandom(32'h8fa3ef69));
        acq_or_sctest  <= 1'b1;
        usb_start_stop <= 1'b0;
        usb_ctest_chn  <= '0;
        usb_dac0       <= '0;
        usb_dac1       <= '0;
        usb_dac2       <= '0;
        usb_param_load <= 1'b0;
        sc_chn         <= '0;
        dac_start      <= '0;
        dac_stop       <= '0;
        rd_en          <= 1'b0;
        hit_drive      <= 3'b111;

        // Reset values, inside and just after
        repeat (3) @(negedge clk);
        assert (rst && !chip_param_load && empty) else note_failure("outputs during reset");
        wait (!rst);
        @(negedge clk);
        assert (!chip_param_load && empty) else note_failure("outputs after reset");
        finish_test("reset");

        // Random host parameter sets with a load strobe each
        repeat (8) begin
            @(posedge clk);
            usb_ctest_chn  <= {$urandom, $urandom};
            usb_dac0       <= 10'($urandom);
            usb_dac1       <= 10'($urandom);
            usb_dac2       <= 10'($urandom);
            usb_param_load <= 1'b1;
            @(posedge clk);
            usb_param_load <= 1'b0;
        end
        finish_test("pass-through");

        // Falling edges on random pin groups while running
        @(posedge clk);
        usb_start_stop <= 1'b1;
        repeat (4) @(posedge clk);
        repeat (HITS) begin
            pins = 3'($urandom_range(7, 1));
            hit_pins.push_back(pins);
            hit_drive <= ~pins;
            repeat (3) @(posedge clk);
            hit_drive <= 3'b111;
            repeat (6) @(posedge clk);
        end
        usb_start_stop <= 1'b0;
        foreach (hit_pins[i]) begin
            read_word(w);
            assert (w[15:14] == sc_test_pkg::TAG_HIT && w[13:11] == hit_pins[i])
                else note_failure($sformatf("hit word %h, pins %b", w, hit_pins[i]));
            assert (i == 0 || w[10:0] > last_ts)
                else note_failure($sformatf("timestamp %0d after %0d", w[10:0], last_ts));
            last_ts = w[10:0];
        end
        repeat (4) @(negedge clk);
        assert (empty) else note_failure("more hit words than edges");
        finish_test("hits");

        // Short scan, read while it runs
        @(posedge clk);
        first = 10'($urandom_range(1023 - SCAN_CODES, 0));
        acq_or_sctest <= 1'b0;
        sc_chn        <= 6'($urandom);
        dac_start     <= first;
        dac_stop      <= first + 10'(SCAN_CODES - 1);
        load_base = load_cnt;
        @(posedge clk);
        usb_start_stop <= 1'b1;
        check_scan(first, SCAN_CODES);
        assert (load_cnt - load_base == SCAN_CODES)
            else note_failure($sformatf("%0d parameter loads", load_cnt - load_base));
        @(posedge clk);
        usb_start_stop <= 1'b0;
        finish_test("scan");

        // Long scan, FIFO left unread until the controller stalls
        repeat (3) @(posedge clk);
        first = 10'($urandom_range(1023 - LONG_CODES, 0));
        dac_start <= first;
        dac_stop  <= first + 10'(LONG_CODES - 1);
        load_base = load_cnt;
        @(posedge clk);
        usb_start_stop <= 1'b1;
        // Half the depth in codes fills it, the next code holds in its write
        wait (load_cnt - load_base == `USB_FIFO_DEPTH / 2 + 1);
        repeat (STEP_CYCLES + 20) @(posedge clk);
        assert (load_cnt - load_base == `USB_FIFO_DEPTH / 2 + 1)
            else note_failure("scan kept loading with a full FIFO");
        check_scan(first, LONG_CODES);
        assert (load_cnt - load_base == LONG_CODES)
            else note_failure($sformatf("%0d parameter loads", load_cnt - load_base));
        @(posedge clk);
        usb_start_stop <= 1'b0;
        finish_test("back-pressure");

        $display("5 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from both scans
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- common/sc_param_if.sv
`timescale 1ns/1ps

// Slow-control parameter set for the front-end ASIC
interface sc_param_if;

    // Test pulse channel, one-hot
    sc_test_pkg::ctest_mask_t ctest_chn;
    // The three threshold DACs
    sc_test_pkg::dac_code_t   dac0;
    sc_test_pkg::dac_code_t   dac1;
    sc_test_pkg::dac_code_t   dac2;
    // Single cycle strobe, new set is valid
    logic                     param_load;

    // Producer of a parameter set
    modport source (output ctest_chn, output dac0, output dac1, output dac2,
                    output param_load);

    // Consumer side, the mode switch
    modport sink (input ctest_chn, input dac0, input dac1, input dac2,
                  input param_load);

endinterface

//--- common/sc_test_cfg.svh
`ifndef SC_TEST_CFG_SVH
`define SC_TEST_CFG_SVH

////////////////////////////////////////
// S-curve scan timing
////////////////////////////////////////

// Cycles after a parameter load before counting starts
`define SC_SETTLE_CYCLES 16

// Trigger counting window per DAC code
`define SC_WINDOW_CYCLES 256

////////////////////////////////////////
// Host side buffering
////////////////////////////////////////
// Words held by the USB data FIFO, power of two
`define USB_FIFO_DEPTH 64

`endif

//--- common/sc_test_pkg.sv
package sc_test_pkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////
    // Threshold DAC code, one per DAC
    typedef logic [9:0]  dac_code_t;
    // One-hot test pulse channel mask
    typedef logic [63:0] ctest_mask_t;
    typedef logic [5:0]  chn_idx_t;
    // Word into the USB data FIFO, tag in 15:14
    typedef logic [15:0] usb_word_t;
    // Saturates at all ones
    typedef logic [13:0] trig_count_t;
    typedef logic [10:0] tstamp_t;

    // S-curve scan controller states
    typedef enum logic [2:0] {
        st_idle, st_load, st_settle, st_count,
        st_wr_code, st_wr_count, st_next, st_wr_end
    } sctest_state_t;

    ////////////////////////////////////////
    // Word tags
    ////////////////////////////////////////
    localparam logic [1:0] TAG_HIT   = 2'b00;
    localparam logic [1:0] TAG_CODE  = 2'b01;
    localparam logic [1:0] TAG_COUNT = 2'b10;
    localparam logic [1:0] TAG_END   = 2'b11;

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build and run the readout core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_scurve_top -f all.f

out=$(./obj_dir/Vtb_scurve_top)
echo "$out"

if ! grep -qx "No errors" <<< "$out"; then
    echo "Simulation reported failures"
    exit 1
fi

//--- sctest/sctest_ctrl.sv
`timescale 1ns/1ps
`include "sc_test_cfg.svh"

// S-curve scan over a DAC code range on one test channel
module sctest_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_stop,
    input  sc_test_pkg::chn_idx_t  sc_chn,
    input  sc_test_pkg::dac_code_t dac_start,
    input  sc_test_pkg::dac_code_t dac_stop,
    input  logic                   trigger_b,
    sc_param_if.source             prm,
    output sc_test_pkg::usb_word_t wr_din,
    output logic                   wr_en,
    input  logic                   fifo_full
);

    // Wide enough for both settle and window
    localparam int TMR_W = $clog2(`SC_SETTLE_CYCLES + `SC_WINDOW_CYCLES);

    sc_test_pkg::sctest_state_t state;
    logic                       start_d;
    logic                       trig_s1;
    logic                       trig_s2;
    logic                       trig_fall;
    logic [TMR_W-1:0]           timer;
    sc_test_pkg::dac_code_t     code;
    sc_test_pkg::ctest_mask_t   mask;
    sc_test_pkg::trig_count_t   trig_cnt;

    ////////////////////////////////////////
    // Start and trigger edges
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            start_d <= 1'b0;
            trig_s1 <= 1'b1;
            trig_s2 <= 1'b1;
        end else begin
            start_d <= start_stop;
            // Two flop sync of the chip pin
            trig_s1 <= trigger_b;
            trig_s2 <= trig_s1;
        end
    end

    // Pin was high and is now low
    assign trig_fall = trig_s2 & ~trig_s1;

    ////////////////////////////////////////
    // Scan FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sc_test_pkg::st_idle;
        end else begin
            case (state)
                sc_test_pkg::st_idle: begin
                    if (start_stop && !start_d) begin
                        state <= sc_test_pkg::st_load;
                    end
                end
                sc_test_pkg::st_load: begin
                    state <= sc_test_pkg::st_settle;
                end
                sc_test_pkg::st_settle: begin
                    if (!start_stop) begin
                        state <= sc_test_pkg::st_wr_end;
                    end else if (timer == TMR_W'(`SC_SETTLE_CYCLES - 1)) begin
                        state <= sc_test_pkg::st_count;
                    end
                end
                sc_test_pkg::st_count: begin
                    if (!start_stop) begin
                        state <= sc_test_pkg::st_wr_end;
                    end else if (timer == TMR_W'(`SC_WINDOW_CYCLES - 1)) begin
                        state <= sc_test_pkg::st_wr_code;
                    end
                end
                // Write states hold while the FIFO is full
                sc_test_pkg::st_wr_code: begin
                    if (!fifo_full) state <= sc_test_pkg::st_wr_count;
                end
                sc_test_pkg::st_wr_count: begin
                    if (!fifo_full) state <= sc_test_pkg::st_next;
                end
                sc_test_pkg::st_next: begin
                    // Leaving after dac_stop also prevents a wrap at 1023
                    if (!start_stop || code >= dac_stop) begin
                        state <= sc_test_pkg::st_wr_end;
                    end else begin
                        state <= sc_test_pkg::st_load;
                    end
                end
                default: begin
                    if (!fifo_full) state <= sc_test_pkg::st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Code, mask, timer and trigger count
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == sc_test_pkg::st_idle) begin
            code <= dac_start;
            mask <= sc_test_pkg::ctest_mask_t'(1) << sc_chn;
        end else if (state == sc_test_pkg::st_next) begin
            code <= code + 1'b1;
        end
        // Timer restarts at each phase boundary
        if (state == sc_test_pkg::st_load) begin
            timer <= '0;
        end else if (state == sc_test_pkg::st_settle &&
                     timer == TMR_W'(`SC_SETTLE_CYCLES - 1)) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
        if (state == sc_test_pkg::st_load) begin
            trig_cnt <= '0;
        end else if (state == sc_test_pkg::st_count && trig_fall && !(&trig_cnt)) begin
            trig_cnt <= trig_cnt + 1'b1;
        end
    end

    // Same code on all three DACs
    assign prm.ctest_chn  = mask;
    assign prm.dac0       = code;
    assign prm.dac1       = code;
    assign prm.dac2       = code;
    assign prm.param_load = (state == sc_test_pkg::st_load);

    ////////////////////////////////////////
    // Result words
    ////////////////////////////////////////
    assign wr_en = !fifo_full && (state == sc_test_pkg::st_wr_code ||
                                  state == sc_test_pkg::st_wr_count ||
                                  state == sc_test_pkg::st_wr_end);

    always_comb begin
        case (state)
            sc_test_pkg::st_wr_code:  wr_din = {sc_test_pkg::TAG_CODE, 4'b0000, code};
            sc_test_pkg::st_wr_count: wr_din = {sc_test_pkg::TAG_COUNT, trig_cnt};
            default:                  wr_din = {sc_test_pkg::TAG_END, 14'd0};
        endcase
    end

    // Stalled result word held until the FIFO takes it
    assert property (@(posedge clk) disable iff (rst)
        (fifo_full && state inside {sc_test_pkg::st_wr_code, sc_test_pkg::st_wr_count,
                                    sc_test_pkg::st_wr_end}) |=> $stable(wr_din));

    // Load strobe is a single pulse
    assert property (@(posedge clk) disable iff (rst) prm.param_load |=> !prm.param_load);

endmodule

//--- verilog/acq_or_sctest_switch.sv
`timescale 1ns/1ps

// Mode switch between acquisition and S-curve test
// acq_or_sctest high selects acquisition
module acq_or_sctest_switch (
    input  logic                     acq_or_sctest,
    // Host start/stop level
    input  logic                     start_stop,
    output logic                     acq_start_stop,
    output logic                     sctest_start_stop,
    // FIFO writers
    input  sc_test_pkg::usb_word_t   acq_wr_din,
    input  logic                     acq_wr_en,
    input  sc_test_pkg::usb_word_t   sct_wr_din,
    input  logic                     sct_wr_en,
    output sc_test_pkg::usb_word_t   fifo_wr_din,
    output logic                     fifo_wr_en,
    // Parameter sets
    sc_param_if.sink                 usb_prm,
    sc_param_if.sink                 sct_prm,
    // To the chip
    output sc_test_pkg::ctest_mask_t chip_ctest_chn,
    output sc_test_pkg::dac_code_t   chip_dac0,
    output sc_test_pkg::dac_code_t   chip_dac1,
    output sc_test_pkg::dac_code_t   chip_dac2,
    output logic                     chip_param_load
);

    ////////////////////////////////////////
    // Start level to one consumer only
    ////////////////////////////////////////
    assign acq_start_stop    = acq_or_sctest ? start_stop : 1'b0;
    assign sctest_start_stop = acq_or_sctest ? 1'b0 : start_stop;

    ////////////////////////////////////////
    // FIFO write path
    ////////////////////////////////////////
    assign fifo_wr_din = acq_or_sctest ? acq_wr_din : sct_wr_din;
    assign fifo_wr_en  = acq_or_sctest ? acq_wr_en  : sct_wr_en;

    ////////////////////////////////////////
    // Slow-control parameters
    ////////////////////////////////////////
    // Host values in acquisition and scan values in test mode
    assign chip_ctest_chn  = acq_or_sctest ? usb_prm.ctest_chn  : sct_prm.ctest_chn;
    assign chip_dac0       = acq_or_sctest ? usb_prm.dac0       : sct_prm.dac0;
    assign chip_dac1       = acq_or_sctest ? usb_prm.dac1       : sct_prm.dac1;
    assign chip_dac2       = acq_or_sctest ? usb_prm.dac2       : sct_prm.dac2;
    assign chip_param_load = acq_or_sctest ? usb_prm.param_load : sct_prm.param_load;

    // A deselected writer must stay quiet or its word is dropped
    always_comb begin
        assert (!(acq_or_sctest ? sct_wr_en : acq_wr_en))
            else $error("write from the deselected FIFO writer");
    end

endmodule

//--- verilog/scurve_top.sv
`timescale 1ns/1ps

// Readout core, acquisition or S-curve test into one USB FIFO
module scurve_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     acq_or_sctest,
    input  logic                     usb_start_stop,
    input  sc_test_pkg::ctest_mask_t usb_ctest_chn,
    input  sc_test_pkg::dac_code_t   usb_dac0,
    input  sc_test_pkg::dac_code_t   usb_dac1,
    input  sc_test_pkg::dac_code_t   usb_dac2,
    input  logic                     usb_param_load,
    input  sc_test_pkg::chn_idx_t    sc_chn,
    input  sc_test_pkg::dac_code_t   dac_start,
    input  sc_test_pkg::dac_code_t   dac_stop,
    input  logic [2:0]               trigger_b,
    output sc_test_pkg::ctest_mask_t chip_ctest_chn,
    output sc_test_pkg::dac_code_t   chip_dac0,
    output sc_test_pkg::dac_code_t   chip_dac1,
    output sc_test_pkg::dac_code_t   chip_dac2,
    output logic                     chip_param_load,
    input  logic                     rd_en,
    output sc_test_pkg::usb_word_t   rd_data,
    output logic                     empty
);

    sc_param_if usb_prm ();
    sc_param_if sct_prm ();

    logic acq_start_stop, sctest_start_stop;
    logic acq_wr_en, sct_wr_en, fifo_wr_en, fifo_full;
    sc_test_pkg::usb_word_t acq_wr_din, sct_wr_din, fifo_wr_din;

    // Host parameter set
    assign usb_prm.ctest_chn  = usb_ctest_chn;
    assign usb_prm.dac0       = usb_dac0;
    assign usb_prm.dac1       = usb_dac1;
    assign usb_prm.dac2       = usb_dac2;
    assign usb_prm.param_load = usb_param_load;

    acq_or_sctest_switch u_switch (.acq_or_sctest, .start_stop(usb_start_stop),
        .acq_start_stop, .sctest_start_stop, .acq_wr_din, .acq_wr_en, .sct_wr_din,
        .sct_wr_en, .fifo_wr_din, .fifo_wr_en, .usb_prm(usb_prm.sink),
        .sct_prm(sct_prm.sink), .chip_ctest_chn, .chip_dac0, .chip_dac1, .chip_dac2,
        .chip_param_load);

    // Scan uses trigger 0 only
    sctest_ctrl u_sctest (.clk, .rst, .start_stop(sctest_start_stop), .sc_chn,
        .dac_start, .dac_stop, .trigger_b(trigger_b[0]), .prm(sct_prm.source),
        .wr_din(sct_wr_din), .wr_en(sct_wr_en), .fifo_full);

    acq_hit_packer u_packer (.clk, .rst, .start_stop(acq_start_stop), .trigger_b,
        .wr_din(acq_wr_din), .wr_en(acq_wr_en), .fifo_full);

    usb_data_fifo u_fifo (.clk, .rst, .wr_en(fifo_wr_en), .rd_en, .wr_din(fifo_wr_din),
        .rd_data, .full(fifo_full), .empty);

endmodule

//--- verilog/usb_data_fifo.sv
`timescale 1ns/1ps
`include "sc_test_cfg.svh"

// Show-ahead FIFO in front of the USB controller
module usb_data_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  sc_test_pkg::usb_word_t wr_din,
    output sc_test_pkg::usb_word_t rd_data,
    output logic                   full,
    output logic                   empty
);

    localparam int PTR_W = $clog2(`USB_FIFO_DEPTH);

    sc_test_pkg::usb_word_t mem [`USB_FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         fill;
    logic                   do_wr;
    logic                   do_rd;

    // Guard both ends
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    ////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (PTR_W+1)'(do_wr) - (PTR_W+1)'(do_rd);
        end
    end

    // Head word valid whenever not empty
    assign rd_data = mem[rd_ptr];
    assign full    = (fill == (PTR_W+1)'(`USB_FIFO_DEPTH));
    assign empty   = (fill == '0);

    // Host must not pop an empty FIFO
    assert property (@(posedge clk) disable iff (rst) !(rd_en && empty));

endmodule
